// ==== vlog.f ====
+incdir+hdl
hdl/u1e_ctrl_pkg.sv
hdl/wb_slave_decode.sv
hdl/settings_bus_fsm.sv
hdl/misc_regs.sv
hdl/vita_time_counter.sv
hdl/readback_regs.sv
hdl/u1e_ctrl_core.sv
tb/u1e_ctrl_asserts.sv
tb/tb_u1e_ctrl.sv

// ==== tb/tb_u1e_ctrl.sv ====
////////////////////////////////////////////////////////////
// testbench for the control plane
// clock, reset, lfsr data, wishbone access tasks,
// six directed tests, watchdog and final report
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "u1e_ctrl_macros.svh"

module tb_u1e_ctrl;

   localparam logic [31:0] TB_TICKS = 32'd50;
   localparam int ACK_TIMEOUT     = 8;
   localparam int NUM_TESTS       = 6;
   localparam int TEST_MAX_CYCLES = 600;    // longest test is the pps one
   localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_MAX_CYCLES + 400;

   logic                  wb_clk, wb_rst, pps_i;
   logic [2:0]            cgen_st_i;
   logic                  cgen_sync_b, cgen_ref_sel;
   logic [3:0]            debug_led;
   u1e_ctrl_pkg::wb_req_t wb_req;
   u1e_ctrl_pkg::wb_rsp_t wb_rsp;

   logic [31:0] lfsr;
   int          errors, checks, test_num, errors_at_start;

   u1e_ctrl_core #(.TICKS_PER_SEC(TB_TICKS)) dut0
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .pps_i(pps_i), .cgen_st_i(cgen_st_i), .cgen_sync_b_o(cgen_sync_b),
      .cgen_ref_sel_o(cgen_ref_sel), .debug_led_o(debug_led));

   initial
   begin
      wb_clk = 1'b0;
      forever #10 wb_clk = ~wb_clk;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge wb_clk);
      $display("watchdog expired before the tests finished");
      $display("Simulation failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // helpers

   // x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] val;
      logic        fb;
      int          i;
      val = '0;
      for (i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic u1e_ctrl_pkg::wb_addr_t set_addr(input logic [5:0] idx, input logic hi);
      return 11'h400 | {3'b000, idx, hi, 1'b0};    // slots 8 and 9
   endfunction

   function automatic u1e_ctrl_pkg::wb_addr_t rb_addr(input logic [3:0] word, input logic hi);
      return 11'h380 | {5'b00000, word, hi, 1'b0};  // slot 7
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_range(input string name, input logic [31:0] got,
                              input logic [31:0] lo, input logic [31:0] hi);
      checks++;
      assert (got >= lo && got <= hi)
      else
      begin
         errors++;
         $display("FAIL %s got %h expected %h to %h", name, got, lo, hi);
      end
   endtask

   // called 2 ns after a rising edge, returns at the same phase
   task automatic bus_access(input logic we, input u1e_ctrl_pkg::wb_addr_t addr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
      int waited;
      waited = 0;
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, sel: 2'b11, dat: wdata};
      @(negedge wb_clk);
      while (!wb_rsp.ack && waited < ACK_TIMEOUT)
      begin
         @(negedge wb_clk);
         waited++;
      end
      assert (wb_rsp.ack)
      else
      begin
         errors++;
         $display("bus access at address %h was never acknowledged", addr);
      end
      rdata = wb_rsp.dat;
      @(posedge wb_clk);
      #2;
      wb_req = '0;
   endtask

   task automatic wb_write(input u1e_ctrl_pkg::wb_addr_t addr, input logic [15:0] data);
      logic [15:0] unused;
      bus_access(1'b1, addr, data, unused);
   endtask

   task automatic wb_read(input u1e_ctrl_pkg::wb_addr_t addr, output logic [15:0] data);
      bus_access(1'b0, addr, 16'h0000, data);
   endtask

   // low half then high half, then let the strobe reach its consumer
   task automatic set_write(input logic [5:0] idx, input logic [31:0] data);
      wb_write(set_addr(idx, 1'b0), data[15:0]);
      wb_write(set_addr(idx, 1'b1), data[31:16]);
      repeat (3) @(posedge wb_clk);
      #2;
   endtask

   task automatic read_rb32(input logic [3:0] word, output logic [31:0] data);
      logic [15:0] lo, hi;
      wb_read(rb_addr(word, 1'b0), lo);
      wb_read(rb_addr(word, 1'b1), hi);
      data = {hi, lo};
   endtask

   task automatic end_test(input string name);
      $display("test %0d %s: %0d errors", test_num, name, errors - errors_at_start);
      test_num++;
      errors_at_start = errors;
   endtask

   ////////////////////////////////////////////////////////////
   // tests

   initial
   begin
      logic [15:0] rd, v_led, v_cgen, v_test;
      logic [31:0] rd32, v32, secs;
      int          assert_fails;
      wb_rst = 1'b1;
      pps_i = 1'b0;
      cgen_st_i = 3'b000;
      wb_req = '0;
      lfsr = 32'h2503_6419;
      errors = 0;
      checks = 0;
      test_num = 1;
      errors_at_start = 0;
      repeat (4) @(posedge wb_clk);
      #2;
      wb_rst = 1'b0;

      check_eq("cgen_sync_b_o", cgen_sync_b, 1'b1);
      check_eq("cgen_ref_sel_o", cgen_ref_sel, 1'b1);
      check_eq("debug_led_o", debug_led, 4'hF);
      wb_read(`U1E_REG_COMPAT, rd);
      check_eq("compat", rd, 16'd4);
      wb_read(11'd2, rd);                       // hole in the misc map
      check_eq("unmapped misc", rd, 16'hBEEF);
      end_test("reset defaults");

      v_led = lfsr_bits(16);
      v_cgen = lfsr_bits(16);
      v_test = lfsr_bits(16);
      cgen_st_i = lfsr_bits(3);
      wb_write(`U1E_REG_LEDS, v_led);
      wb_write(`U1E_REG_CGEN_CTRL, v_cgen);
      wb_write(`U1E_REG_TEST, v_test);
      wb_read(`U1E_REG_LEDS, rd);
      check_eq("leds", rd, v_led);
      wb_read(`U1E_REG_CGEN_CTRL, rd);
      check_eq("cgen_ctrl", rd, v_cgen);
      wb_read(`U1E_REG_TEST, rd);
      check_eq("test", rd, v_test);
      check_eq("debug_led_o", debug_led, {28'd0, ~v_led[3:0]});
      check_eq("cgen_sync_b_o", cgen_sync_b, v_cgen[1]);
      check_eq("cgen_ref_sel_o", cgen_ref_sel, v_cgen[0]);
      wb_read(`U1E_REG_CGEN_ST, rd);
      check_eq("cgen_st", rd, {13'd0, cgen_st_i});
      end_test("misc registers");

      v32 = lfsr_bits(32) | 32'd1;
      set_write(`U1E_SR_TEST32, v32);
      read_rb32(4'd4, rd32);
      check_eq("test32", rd32, v32);
      wb_write(set_addr(`U1E_SR_TEST32, 1'b1), lfsr_bits(16));   // high half alone
      repeat (3) @(posedge wb_clk);
      #2;
      read_rb32(4'd4, rd32);
      check_eq("test32 after lone high", rd32, v32);
      wb_write(set_addr(`U1E_SR_TEST32, 1'b0), lfsr_bits(16));
      wb_write(set_addr(`U1E_SR_TEST32 + 1, 1'b1), lfsr_bits(16));
      repeat (3) @(posedge wb_clk);
      #2;
      read_rb32(4'd4, rd32);
      check_eq("test32 after index mismatch", rd32, v32);
      end_test("settings pairs");

      secs = lfsr_bits(12) + 32'd1;
      set_write(`U1E_SR_TIME64, secs);
      set_write(`U1E_SR_TIME64 + 1, 32'd0);
      set_write(`U1E_SR_TIME64 + 2, 32'd1);        // load on next pps
      pps_i = 1'b1;
      repeat (4) @(posedge wb_clk);
      #2;
      pps_i = 1'b0;
      repeat (4) @(posedge wb_clk);
      #2;
      read_rb32(4'd2, rd32);
      check_eq("pps seconds", rd32, secs);
      read_rb32(4'd3, rd32);
      check_eq("pps ticks", rd32, 32'd0);
      repeat (120) @(posedge wb_clk);
      #2;
      read_rb32(4'd0, rd32);
      check_range("time seconds", rd32, secs + 32'd2, 32'hFFFF_FFFF);
      end_test("pps time load");

      secs = lfsr_bits(12) + 32'd100;
      set_write(`U1E_SR_TIME64, secs);
      set_write(`U1E_SR_TIME64 + 1, 32'd0);
      set_write(`U1E_SR_TIME64 + 2, 32'd0);        // load right away
      repeat (60) @(posedge wb_clk);
      #2;
      read_rb32(4'd0, rd32);
      check_range("time seconds", rd32, secs + 32'd1, secs + 32'd2);
      end_test("immediate time load");

      wb_write(`U1E_REG_TEST, lfsr_bits(16) | 16'd1);
      wb_write(`U1E_REG_LEDS, lfsr_bits(16) | 16'd1);
      set_write(`U1E_SR_GLOBAL_RESET, lfsr_bits(32));
      wb_read(`U1E_REG_TEST, rd);
      check_eq("test after soft reset", rd, 16'd0);
      wb_read(`U1E_REG_LEDS, rd);
      check_eq("leds after soft reset", rd, 16'd0);
      check_eq("debug_led_o", debug_led, 4'hF);
      read_rb32(4'd4, rd32);
      check_eq("test32 after soft reset", rd32, 32'd0);
      wb_read(`U1E_REG_CGEN_CTRL, rd);
      check_eq("cgen_ctrl after soft reset", rd, 16'd3);
      end_test("soft reset");

      assert_fails = dut0.asserts0.fail_count;
      $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
               NUM_TESTS, checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== tb/u1e_ctrl_asserts.sv ====
////////////////////////////////////////////////////////////
// bound concurrent assertions for the control plane
// wishbone acknowledge, settings strobe, time counting
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "u1e_ctrl_macros.svh"

module u1e_ctrl_asserts
  #(parameter logic [31:0] TICKS_PER_SEC = `U1E_TICKS_PER_SEC)
   (input logic                     wb_clk,
    input logic                     wb_rst,
    input logic                     core_rst_i,
    input u1e_ctrl_pkg::wb_req_t    wb_req_i,
    input u1e_ctrl_pkg::wb_rsp_t    wb_rsp_i,
    input u1e_ctrl_pkg::wb_req_t    set_req_i,
    input u1e_ctrl_pkg::set_bus_t   set_bus_i,
    input logic                     pps_i,
    input u1e_ctrl_pkg::vita_time_t vita_time_i);

   int         fail_count = 0;   // assertion failures so far
   logic [3:0] slot;
   logic       mapped, set_wr, hi_done;
   logic       have_low;         // expected settings state, low half held
   logic [5:0] low_idx;
   logic [2:0] pps_sync;
   logic       pps_edge;

   assign slot    = wb_req_i.adr[10:7];
   assign mapped  = (slot == `U1E_SLOT_MISC) || (slot == `U1E_SLOT_RB32) ||
                    (slot == `U1E_SLOT_SET) || (slot == `U1E_SLOT_SET + 4'd1);
   assign set_wr  = set_req_i.cyc & set_req_i.stb & set_req_i.we;
   assign hi_done = set_wr & set_req_i.adr[1] & have_low & (set_req_i.adr[7:2] == low_idx);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         have_low <= 1'b0;
      else if (set_wr)
      begin
         have_low <= ~set_req_i.adr[1];
         low_idx  <= set_req_i.adr[7:2];
      end
   end

   // pps edge as the counter sees it, loads may happen there
   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
         pps_sync <= 3'b000;
      else
         pps_sync <= {pps_sync[1:0], pps_i};
   end

   assign pps_edge = pps_sync[1] & ~pps_sync[2];

   ////////////////////////////////////////////////////////////
   // properties

   ack_mapped : assert property (@(posedge wb_clk)
      wb_req_i.cyc && wb_req_i.stb && mapped |-> wb_rsp_i.ack)
      else begin fail_count++; $error("no same-cycle ack on a mapped slot"); end

   stb_after_write : assert property (@(posedge wb_clk) disable iff (wb_rst)
      hi_done |=> set_bus_i.stb)
      else begin fail_count++; $error("settings strobe missing after a completed pair"); end

   stb_cause : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_bus_i.stb |-> $past(hi_done))
      else begin fail_count++; $error("settings strobe without a completed pair"); end

   stb_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_bus_i.stb |=> !set_bus_i.stb)
      else begin fail_count++; $error("settings strobe longer than one cycle"); end

   ticks_range : assert property (@(posedge wb_clk) disable iff (core_rst_i)
      vita_time_i[31:0] < TICKS_PER_SEC)
      else begin fail_count++; $error("ticks reached the tick rate"); end

   secs_wrap : assert property (@(posedge wb_clk) disable iff (core_rst_i)
      (vita_time_i[31:0] == TICKS_PER_SEC - 32'd1) && !set_bus_i.stb && !pps_edge
      |=> (vita_time_i[31:0] == 32'd0) &&
          (vita_time_i[63:32] == $past(vita_time_i[63:32]) + 32'd1))
      else begin fail_count++; $error("seconds did not step on a tick wrap"); end

endmodule

bind u1e_ctrl_core u1e_ctrl_asserts #(.TICKS_PER_SEC(TICKS_PER_SEC)) asserts0
  (.wb_clk(wb_clk), .wb_rst(wb_rst), .core_rst_i(core_rst), .wb_req_i(wb_req_i),
   .wb_rsp_i(wb_rsp_o), .set_req_i(set_req), .set_bus_i(set_bus), .pps_i(pps_i),
   .vita_time_i(vita_time));

// ==== hdl/u1e_ctrl_core.sv ====
////////////////////////////////////////////////////////////
// control plane top level
// decoder, settings bus, misc registers, time counter
// and the 32-bit readback window
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "u1e_ctrl_macros.svh"

module u1e_ctrl_core
  #(parameter logic [31:0] TICKS_PER_SEC = `U1E_TICKS_PER_SEC)
   (input  logic                 wb_clk,
    input  logic                 wb_rst,
    input  u1e_ctrl_pkg::wb_req_t wb_req_i,
    output u1e_ctrl_pkg::wb_rsp_t wb_rsp_o,
    input  logic                 pps_i,
    input  logic [2:0]           cgen_st_i,
    output logic                 cgen_sync_b_o,
    output logic                 cgen_ref_sel_o,
    output logic [3:0]           debug_led_o);

   u1e_ctrl_pkg::wb_req_t    misc_req, rb_req, set_req;
   u1e_ctrl_pkg::wb_rsp_t    misc_rsp, rb_rsp;
   logic                     set_ack;
   u1e_ctrl_pkg::set_bus_t   set_bus;
   logic                     core_rst;   // wb_rst or soft reset
   u1e_ctrl_pkg::vita_time_t vita_time, vita_time_pps;

   ////////////////////////////////////////////////////////////
   // bus fabric and settings

   wb_slave_decode u_decode
     (.wb_req_i(wb_req_i), .misc_req_o(misc_req), .rb_req_o(rb_req),
      .set_req_o(set_req), .misc_rsp_i(misc_rsp), .rb_rsp_i(rb_rsp),
      .set_ack_i(set_ack), .wb_rsp_o(wb_rsp_o));

   settings_bus_fsm u_settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .req_i(set_req), .ack_o(set_ack),
      .set_bus_o(set_bus), .core_rst_o(core_rst));

   ////////////////////////////////////////////////////////////
   // slaves

   misc_regs u_misc
     (.wb_clk(wb_clk), .core_rst_i(core_rst), .req_i(misc_req), .rsp_o(misc_rsp),
      .cgen_st_i(cgen_st_i), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o), .debug_led_o(debug_led_o));

   vita_time_counter #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_time
     (.wb_clk(wb_clk), .core_rst_i(core_rst), .set_bus_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   readback_regs u_readback
     (.wb_clk(wb_clk), .core_rst_i(core_rst), .set_bus_i(set_bus), .req_i(rb_req),
      .rsp_o(rb_rsp), .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps));

endmodule

// ==== hdl/readback_regs.sv ====
////////////////////////////////////////////////////////////
// 32-bit readback window on slot 7
// time, pps time and test setting in 16-bit halves
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "u1e_ctrl_macros.svh"

module readback_regs
   (input  logic                     wb_clk,
    input  logic                     core_rst_i,
    input  u1e_ctrl_pkg::set_bus_t   set_bus_i,
    input  u1e_ctrl_pkg::wb_req_t    req_i,
    output u1e_ctrl_pkg::wb_rsp_t    rsp_o,
    input  u1e_ctrl_pkg::vita_time_t vita_time_i,
    input  u1e_ctrl_pkg::vita_time_t vita_time_pps_i);

   u1e_ctrl_pkg::set_data_t reg_test32;
   u1e_ctrl_pkg::set_data_t word;

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
         reg_test32 <= '0;
      else if (set_bus_i.stb && set_bus_i.addr == `U1E_SR_TEST32)
         reg_test32 <= set_bus_i.data;
   end

   // word select on address bits 5:2
   always_comb
   begin
      case (req_i.adr[5:2])
         4'd0    : word = vita_time_i[63:32];       // seconds
         4'd1    : word = vita_time_i[31:0];        // ticks
         4'd2    : word = vita_time_pps_i[63:32];
         4'd3    : word = vita_time_pps_i[31:0];
         4'd4    : word = reg_test32;
         default : word = '0;
      endcase
   end

   assign rsp_o.dat = req_i.adr[1] ? word[31:16] : word[15:0];
   assign rsp_o.ack = req_i.cyc & req_i.stb;

endmodule

// ==== hdl/vita_time_counter.sv ====
////////////////////////////////////////////////////////////
// 64-bit vita time, seconds and ticks
// immediate or pps aligned load, pps time latch
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "u1e_ctrl_macros.svh"

module vita_time_counter
  #(parameter logic [31:0] TICKS_PER_SEC = `U1E_TICKS_PER_SEC)
   (input  logic                     wb_clk,
    input  logic                     core_rst_i,
    input  u1e_ctrl_pkg::set_bus_t   set_bus_i,
    input  logic                     pps_i,
    output u1e_ctrl_pkg::vita_time_t vita_time_o,
    output u1e_ctrl_pkg::vita_time_t vita_time_pps_o);

   localparam u1e_ctrl_pkg::set_addr_t SR_SECS = `U1E_SR_TIME64;
   localparam u1e_ctrl_pkg::set_addr_t SR_TICKS = `U1E_SR_TIME64 + 8'd1;
   localparam u1e_ctrl_pkg::set_addr_t SR_ARM = `U1E_SR_TIME64 + 8'd2;

   u1e_ctrl_pkg::set_data_t  pend_secs, pend_ticks;
   u1e_ctrl_pkg::set_data_t  secs, ticks;
   u1e_ctrl_pkg::vita_time_t time_pps;
   logic                     armed_pps;
   logic                     pps_d1, pps_d2, pps_d3;
   logic                     pps_edge;
   logic                     arm_stb, load_now;

   // pending time, plain payload
   always_ff @(posedge wb_clk)
   begin
      if (set_bus_i.stb && set_bus_i.addr == SR_SECS)
         pend_secs <= set_bus_i.data;
      if (set_bus_i.stb && set_bus_i.addr == SR_TICKS)
         pend_ticks <= set_bus_i.data;
   end

   assign arm_stb  = set_bus_i.stb && (set_bus_i.addr == SR_ARM);
   assign load_now = arm_stb & ~set_bus_i.data[0];

   ////////////////////////////////////////////////////////////
   // pps sync and edge detect

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
         {pps_d3, pps_d2, pps_d1} <= 3'b000;
      else
         {pps_d3, pps_d2, pps_d1} <= {pps_d2, pps_d1, pps_i};
   end

   assign pps_edge = pps_d2 & ~pps_d3;

   ////////////////////////////////////////////////////////////
   // counter and latch

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         secs      <= '0;
         ticks     <= '0;
         time_pps  <= '0;
         armed_pps <= 1'b0;
      end
      else
      begin
         if (load_now || (pps_edge && armed_pps))   // immediate or pps aligned load
         begin
            secs  <= pend_secs;
            ticks <= pend_ticks;
         end
         else if (ticks == TICKS_PER_SEC - 32'd1)
         begin
            secs  <= secs + 32'd1;   // wrap into next second
            ticks <= '0;
         end
         else
            ticks <= ticks + 32'd1;

         if (pps_edge)
            time_pps <= armed_pps ? {pend_secs, pend_ticks} : {secs, ticks};

         if (arm_stb)
            armed_pps <= set_bus_i.data[0];
         else if (pps_edge)
            armed_pps <= 1'b0;
      end
   end

   assign vita_time_o     = {secs, ticks};
   assign vita_time_pps_o = time_pps;

endmodule

// ==== hdl/misc_regs.sv ====
////////////////////////////////////////////////////////////
// misc registers on slot 0
// leds, clock generator control/status, test, compat
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "u1e_ctrl_macros.svh"

module misc_regs
   (input  logic                  wb_clk,
    input  logic                  core_rst_i,
    input  u1e_ctrl_pkg::wb_req_t req_i,
    output u1e_ctrl_pkg::wb_rsp_t rsp_o,
    input  logic [2:0]            cgen_st_i,
    output logic                  cgen_sync_b_o,
    output logic                  cgen_ref_sel_o,
    output logic [3:0]            debug_led_o);

   u1e_ctrl_pkg::wb_data_t reg_leds, reg_cgen_ctrl, reg_test;
   logic [6:0]             offs;

   assign offs = req_i.adr[6:0];

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= 16'd3;      // sync_b and ref_sel high
         reg_test      <= '0;
      end
      else if (req_i.cyc & req_i.stb & req_i.we)
      begin
         case (offs)
            `U1E_REG_LEDS      : reg_leds      <= req_i.dat;
            `U1E_REG_CGEN_CTRL : reg_cgen_ctrl <= req_i.dat;
            `U1E_REG_TEST      : reg_test      <= req_i.dat;
            default            : ;
         endcase
      end
   end

   always_comb
   begin
      case (offs)
         `U1E_REG_LEDS      : rsp_o.dat = reg_leds;
         `U1E_REG_CGEN_CTRL : rsp_o.dat = reg_cgen_ctrl;
         `U1E_REG_CGEN_ST   : rsp_o.dat = {13'd0, cgen_st_i};
         `U1E_REG_TEST      : rsp_o.dat = reg_test;
         `U1E_REG_COMPAT    : rsp_o.dat = {8'd0, `U1E_COMPAT_NUM};
         default            : rsp_o.dat = `U1E_UNMAPPED_DATA;
      endcase
   end

   assign rsp_o.ack = req_i.cyc & req_i.stb;   // single cycle access

   assign debug_led_o    = ~reg_leds[3:0];      // leds are active low
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

endmodule

// ==== hdl/settings_bus_fsm.sv ====
////////////////////////////////////////////////////////////
// settings bus from two 16-bit wishbone writes
// one-cycle strobe and soft reset pulse
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "u1e_ctrl_macros.svh"

module settings_bus_fsm
   (input  logic                   wb_clk,
    input  logic                   wb_rst,
    input  u1e_ctrl_pkg::wb_req_t  req_i,
    output logic                   ack_o,
    output u1e_ctrl_pkg::set_bus_t set_bus_o,
    output logic                   core_rst_o);

   u1e_ctrl_pkg::set_state_e state, state_nxt;
   u1e_ctrl_pkg::wb_data_t   low_q;        // stored low half
   logic [5:0]               idx_q;        // stored setting index
   logic                     set_stb_q;
   u1e_ctrl_pkg::set_addr_t  set_addr_q;
   u1e_ctrl_pkg::set_data_t  set_data_q;
   logic                     rst_pulse;
   logic                     wr, wr_low, wr_high, complete;
   logic [5:0]               idx;

   assign wr       = req_i.cyc & req_i.stb & req_i.we;
   assign idx      = req_i.adr[7:2];
   assign wr_low   = wr & ~req_i.adr[1];
   assign wr_high  = wr & req_i.adr[1];
   assign complete = wr_high & (state == u1e_ctrl_pkg::SET_HAVE_LOW) & (idx == idx_q);

   assign ack_o = req_i.cyc & req_i.stb;

   always_comb
   begin
      state_nxt = state;
      case (state)
         u1e_ctrl_pkg::SET_HAVE_LOW :
            if (complete)
               state_nxt = u1e_ctrl_pkg::SET_STROBE;
            else if (wr_high)
               state_nxt = u1e_ctrl_pkg::SET_IDLE;   // index mismatch
         default :
            // idle and strobe cycles look only for a new low half
            if (wr_low)
               state_nxt = u1e_ctrl_pkg::SET_HAVE_LOW;
            else
               state_nxt = u1e_ctrl_pkg::SET_IDLE;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // control state

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         state     <= u1e_ctrl_pkg::SET_IDLE;
         set_stb_q <= 1'b0;
         rst_pulse <= 1'b0;
      end
      else
      begin
         state     <= state_nxt;
         set_stb_q <= complete;
         rst_pulse <= set_stb_q & (set_addr_q == `U1E_SR_GLOBAL_RESET);
      end
   end

   // payload
   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
      begin
         low_q <= req_i.dat;
         idx_q <= idx;
      end
      if (complete)
      begin
         set_addr_q <= {2'b00, idx_q};
         set_data_q <= {req_i.dat, low_q};
      end
   end

   assign set_bus_o  = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};
   assign core_rst_o = wb_rst | rst_pulse;

endmodule

// ==== hdl/wb_slave_decode.sv ====
////////////////////////////////////////////////////////////
// single master wishbone decoder
// slot match on address bits 10:7, response mux
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "u1e_ctrl_macros.svh"

module wb_slave_decode
   (input  u1e_ctrl_pkg::wb_req_t wb_req_i,
    output u1e_ctrl_pkg::wb_req_t misc_req_o,
    output u1e_ctrl_pkg::wb_req_t rb_req_o,
    output u1e_ctrl_pkg::wb_req_t set_req_o,
    input  u1e_ctrl_pkg::wb_rsp_t misc_rsp_i,
    input  u1e_ctrl_pkg::wb_rsp_t rb_rsp_i,
    input  logic                  set_ack_i,
    output u1e_ctrl_pkg::wb_rsp_t wb_rsp_o);

   localparam logic [2:0] SET_PAIR = 3'(`U1E_SLOT_SET >> 1);   // slots 8 and 9

   logic [3:0] slot;
   logic       misc_hit, rb_hit, set_hit;

   assign slot     = wb_req_i.adr[10:7];
   assign misc_hit = (slot == `U1E_SLOT_MISC);
   assign rb_hit   = (slot == `U1E_SLOT_RB32);
   assign set_hit  = (slot[3:1] == SET_PAIR);

   // every slave sees the request, only the addressed one its strobe
   always_comb
   begin
      misc_req_o     = wb_req_i;
      misc_req_o.stb = wb_req_i.stb & misc_hit;
      rb_req_o       = wb_req_i;
      rb_req_o.stb   = wb_req_i.stb & rb_hit;
      set_req_o      = wb_req_i;
      set_req_o.stb  = wb_req_i.stb & set_hit;
   end

   always_comb
   begin
      wb_rsp_o = '0;                     // unmapped slots never ack
      if (misc_hit)
         wb_rsp_o = misc_rsp_i;
      else if (rb_hit)
         wb_rsp_o = rb_rsp_i;
      else if (set_hit)
         wb_rsp_o.ack = set_ack_i;       // settings reads carry no data
   end

endmodule

// ==== hdl/u1e_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types of the control plane
// bus words, wishbone request/response, settings bus
////////////////////////////////////////////////////////////
`include "u1e_ctrl_macros.svh"

package u1e_ctrl_pkg;

   typedef logic [`U1E_WB_DW-1:0]  wb_data_t;
   typedef logic [`U1E_WB_AW-1:0]  wb_addr_t;
   typedef logic [`U1E_SET_AW-1:0] set_addr_t;
   typedef logic [`U1E_SET_DW-1:0] set_data_t;
   typedef logic [63:0]            vita_time_t;   // secs high, ticks low

   // master to slave
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      wb_addr_t   adr;
      logic [1:0] sel;
      wb_data_t   dat;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic     ack;
      wb_data_t dat;
   } wb_rsp_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   typedef enum logic [1:0] {
      SET_IDLE,
      SET_HAVE_LOW,
      SET_STROBE
   } set_state_e;

endpackage

// ==== hdl/u1e_ctrl_macros.svh ====
////////////////////////////////////////////////////////////
// bus widths, slave slots and misc register offsets
// settings addresses and default tick rate
////////////////////////////////////////////////////////////
`ifndef U1E_CTRL_MACROS_SVH
`define U1E_CTRL_MACROS_SVH

// wishbone and settings bus widths
`define U1E_WB_DW            16
`define U1E_WB_AW            11
`define U1E_SET_AW           8
`define U1E_SET_DW           32

// slave slots on address bits 10:7
`define U1E_SLOT_MISC        4'd0
`define U1E_SLOT_RB32        4'd7
`define U1E_SLOT_SET         4'd8    // takes 8 and 9

// misc register byte offsets
`define U1E_REG_LEDS         7'd0
`define U1E_REG_CGEN_CTRL    7'd4
`define U1E_REG_CGEN_ST      7'd6
`define U1E_REG_TEST         7'd8
`define U1E_REG_COMPAT       7'd16

`define U1E_COMPAT_NUM       8'd4
`define U1E_UNMAPPED_DATA    16'hBEEF

// settings addresses
`define U1E_SR_TIME64        8'd42   // secs, ticks, arm
`define U1E_SR_TEST32        8'd60
`define U1E_SR_GLOBAL_RESET  8'd63

`define U1E_TICKS_PER_SEC    32'd64000000

`endif
